//--- sources.f
tmds_pkg.sv
video_pkg.sv
tmds_encode.sv
video_timing.sv
pattern_gen.sv
dvi_cfg_regs.sv
dvi_tx_top.sv
tb_dvi_tx.sv

//--- run_sim.sh
#!/bin/sh
# build the DVI transmit testbench with Verilator, run it, judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_dvi_tx -f sources.f \
  && ./obj_dir/Vtb_dvi_tx > sim.log 2>&1 \
  || { echo "build or run error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
exit 0

//--- tb_dvi_tx.sv
module tb_dvi_tx;

  // small raster so a frame is only a few hundred cycles
  localparam int H_ACTIVE = 16;
  localparam int H_FP     = 2;
  localparam int H_SYNC   = 3;
  localparam int H_BP     = 3;
  localparam int V_ACTIVE = 4;
  localparam int V_FP     = 1;
  localparam int V_SYNC   = 1;
  localparam int V_BP     = 1;
  localparam int H_TOT     = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int V_TOT     = V_ACTIVE + V_FP + V_SYNC + V_BP;
  localparam int FRAME_CYC = H_TOT * V_TOT;

  logic                 sys_clk;
  logic                 sys_rst_n;
  logic                 wr_en;
  video_pkg::cfg_addr_t wr_addr;
  logic [23:0]          wr_data;
  tmds_pkg::tmds_word_t tmds_ch0;
  tmds_pkg::tmds_word_t tmds_ch1;
  tmds_pkg::tmds_word_t tmds_ch2;

  dvi_tx_top #(
    .H_ACTIVE (H_ACTIVE),
    .H_FP     (H_FP),
    .H_SYNC   (H_SYNC),
    .H_BP     (H_BP),
    .V_ACTIVE (V_ACTIVE),
    .V_FP     (V_FP),
    .V_SYNC   (V_SYNC),
    .V_BP     (V_BP)
  ) dvi_tx_top_i (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .tmds_ch0  (tmds_ch0),
    .tmds_ch1  (tmds_ch1),
    .tmds_ch2  (tmds_ch2)
  );

  always #5 sys_clk = ~sys_clk;             // period 10

  integer              seed = 81;
  int                  err_cnt = 0;
  int                  pass_tests = 0;
  int                  fail_tests = 0;
  int                  frame_cnt = 0;       // frame starts seen at the output
  // register model, staging side and the copy the current frame uses
  video_pkg::pattern_t mdl_pat = video_pkg::pat_solid;
  video_pkg::rgb_t     mdl_rgb = '0;
  video_pkg::pattern_t cur_pat = video_pkg::pat_solid;
  video_pkg::rgb_t     cur_rgb = '0;
  // checker state
  logic                token_seen = 1'b0;
  logic                anchored = 1'b0;     // first data word found
  int                  cyc = 0;             // cycles since pixel 0,0 of frame 0
  int                  run = 0;             // data words so far in this line
  int                  lines = 0;           // active lines since vsync rose
  int                  last_hs = -1;
  logic                hs_prev = 1'b0;
  logic                vs_prev = 1'b0;
  int                  disp [3];            // tracked balance per channel

  //////////////////////////////////////////
  // reference models
  //////////////////////////////////////////

  // dvi 8b/10b rule, word out plus updated running disparity
  function automatic tmds_pkg::tmds_word_t encode_expected(input logic [7:0] d,
                                                          input int disp_in,
                                                          output int disp_out);
    logic [8:0]           qm;
    logic                 xn;
    int                   n1d;
    int                   n1q;
    int                   n0q;
    int                   i;
    tmds_pkg::tmds_word_t w;
    n1d = $countones(d);
    xn  = (n1d > 4) || ((n1d == 4) && !d[0]);  // ones heavy, use xnor
    qm[0] = d[0];
    for (i = 1; i < 8; i++) begin
      qm[i] = xn ? ~(qm[i-1] ^ d[i]) : (qm[i-1] ^ d[i]);
    end
    qm[8] = !xn;
    n1q = $countones(qm[7:0]);
    n0q = 8 - n1q;
    if ((disp_in == 0) || (n1q == n0q)) begin
      w        = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
      disp_out = qm[8] ? (disp_in + n1q - n0q) : (disp_in + n0q - n1q);
    end else if (((disp_in > 0) && (n1q > n0q)) || ((disp_in < 0) && (n0q > n1q))) begin
      w        = {1'b1, qm[8], ~qm[7:0]};   // invert to pull the balance back
      disp_out = disp_in + (qm[8] ? 2 : 0) + n0q - n1q;
    end else begin
      w        = {1'b0, qm[8], qm[7:0]};
      disp_out = disp_in - (qm[8] ? 0 : 2) + n1q - n0q;
    end
    return w;
  endfunction

  function automatic logic [7:0] decode_word(input tmds_pkg::tmds_word_t w);
    logic [7:0] d;
    logic [7:0] b;
    int         i;
    d    = w[9] ? ~w[7:0] : w[7:0];         // undo dc inversion
    b[0] = d[0];
    for (i = 1; i < 8; i++) begin
      b[i] = w[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
    end
    return b;
  endfunction

  function automatic logic is_token(input tmds_pkg::tmds_word_t w);
    return (w == tmds_pkg::ctrl_token_0) || (w == tmds_pkg::ctrl_token_1) ||
           (w == tmds_pkg::ctrl_token_2) || (w == tmds_pkg::ctrl_token_3);
  endfunction

  function automatic tmds_pkg::tmds_word_t token_for(input logic vs, input logic hs);
    case ({vs, hs})
      2'b00:   return tmds_pkg::ctrl_token_0;
      2'b01:   return tmds_pkg::ctrl_token_1;
      2'b10:   return tmds_pkg::ctrl_token_2;
      default: return tmds_pkg::ctrl_token_3;
    endcase
  endfunction

  function automatic video_pkg::rgb_t pixel_expected(input video_pkg::pattern_t pat,
                                                     input video_pkg::rgb_t solid,
                                                     input int x, input int y);
    logic [2:0] bar;
    bar = 3'(x / (H_ACTIVE / 8));
    case (pat)
      video_pkg::pat_solid: return solid;
      video_pkg::pat_bars:  return {{8{bar[2]}}, {8{bar[1]}}, {8{bar[0]}}};
      video_pkg::pat_hramp: return {3{8'(x)}};
      default:              return {3{8'(x ^ y)}};
    endcase
  endfunction

  //////////////////////////////////////////
  // output checker, one call per cycle
  //////////////////////////////////////////

  task automatic check_cycle;
    int                   h;
    int                   v;
    int                   c;
    int                   dnext;
    logic                 exp_de;
    logic                 exp_hs;
    logic                 exp_vs;
    logic                 hs_now;
    logic                 vs_now;
    tmds_pkg::tmds_word_t w;
    tmds_pkg::tmds_word_t tok;
    logic [7:0]           got;
    logic [7:0]           want;
    video_pkg::rgb_t      px;
    h      = cyc % H_TOT;
    v      = (cyc / H_TOT) % V_TOT;
    exp_de = anchored && (h < H_ACTIVE) && (v < V_ACTIVE);
    exp_hs = anchored && (h >= H_ACTIVE + H_FP) && (h < H_ACTIVE + H_FP + H_SYNC);
    exp_vs = anchored && (v >= V_ACTIVE + V_FP) && (v < V_ACTIVE + V_FP + V_SYNC);
    if (exp_de && (run == 0) && (lines == 0)) begin
      frame_cnt++;                          // new frame picks up staged settings
      cur_pat = mdl_pat;
      cur_rgb = mdl_rgb;
    end
    px = pixel_expected(cur_pat, cur_rgb, run, lines);
    for (c = 0; c < 3; c++) begin
      w = (c == 0) ? tmds_ch0 : ((c == 1) ? tmds_ch1 : tmds_ch2);
      if (exp_de) begin
        if (is_token(w)) begin
          $display("ERROR %0t tmds_ch%0d exp data word got token %h", $time, c, w);
          err_cnt++;
        end else begin
          got  = decode_word(w);
          want = px[8*c +: 8];
          if (got != want) begin
            $display("ERROR %0t tmds_ch%0d pixel exp %h got %h", $time, c, want, got);
            err_cnt++;
          end
          tok = encode_expected(got, disp[c], dnext);
          if (w != tok) begin
            $display("ERROR %0t tmds_ch%0d word exp %h got %h", $time, c, tok, w);
            err_cnt++;
          end
          disp[c] = dnext;
        end
      end else begin
        tok = (c == 0) ? token_for(exp_vs, exp_hs) : tmds_pkg::ctrl_token_0;
        if (w != tok) begin
          $display("ERROR %0t tmds_ch%0d token exp %h got %h", $time, c, tok, w);
          err_cnt++;
        end
        disp[c] = 0;                        // balance restarts in blanking
      end
    end
    // line and frame structure seen on channel 0 alone
    hs_now = (tmds_ch0 == tmds_pkg::ctrl_token_1) || (tmds_ch0 == tmds_pkg::ctrl_token_3);
    vs_now = (tmds_ch0 == tmds_pkg::ctrl_token_2) || (tmds_ch0 == tmds_pkg::ctrl_token_3);
    if (!is_token(tmds_ch0)) begin
      run++;
    end else if (run > 0) begin
      if (run != H_ACTIVE) begin
        $display("ERROR %0t tmds_ch0 data run exp %0d got %0d", $time, H_ACTIVE, run);
        err_cnt++;
      end
      lines++;
      run = 0;
    end
    if (hs_now && !hs_prev) begin
      if ((last_hs >= 0) && (cyc - last_hs != H_TOT)) begin
        $display("ERROR %0t hsync period exp %0d got %0d", $time, H_TOT, cyc - last_hs);
        err_cnt++;
      end
      last_hs = cyc;
    end
    if (vs_now && !vs_prev) begin
      if (lines != V_ACTIVE) begin
        $display("ERROR %0t active lines exp %0d got %0d", $time, V_ACTIVE, lines);
        err_cnt++;
      end
      lines = 0;
    end
    hs_prev = hs_now;
    vs_prev = vs_now;
    if (anchored) cyc++;
  endtask

  // outputs move on the rising edge, so look at them on the falling one
  always @(negedge sys_clk) begin
    if (!token_seen) begin
      if (is_token(tmds_ch0)) begin
        token_seen = 1'b1;
      end else if ((tmds_ch0 != '0) || (tmds_ch1 != '0) || (tmds_ch2 != '0)) begin
        $display("ERROR %0t tmds_ch0..2 exp 000 got %h %h %h",
                 $time, tmds_ch0, tmds_ch1, tmds_ch2);
        err_cnt++;
      end
    end
    if (token_seen && !anchored && !is_token(tmds_ch0)) begin
      anchored = 1'b1;                      // pixel 0,0 of frame 0
      cyc      = 0;
    end
    if (token_seen) check_cycle();
  end

  //////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////

  task automatic skip_cycles(input int n);
    repeat (n) @(posedge sys_clk);
    #1;
  endtask

  task automatic wait_frames(input int n);
    int target;
    target = frame_cnt + n;
    while (frame_cnt < target) @(posedge sys_clk);
    #1;
  endtask

  // call 1 after a rising edge, strobe is high for one edge
  task automatic write_reg(input logic addr, input logic [23:0] data);
    wr_en   = 1'b1;
    wr_addr = addr;
    wr_data = data;
    @(posedge sys_clk);
    #1;
    wr_en = 1'b0;
    if (addr) mdl_rgb = data;
    else mdl_pat = video_pkg::pattern_t'(data[1:0]);
  endtask

  task automatic finish_test(input string name, input int mark);
    if (err_cnt == mark) begin
      pass_tests++;
      $display("test %s passed", name);
    end else begin
      fail_tests++;
      $display("test %s failed with %0d errors", name, err_cnt - mark);
    end
  endtask

  // write mid frame, the next frame shows it in full
  task automatic run_pattern(input video_pkg::pattern_t pat, input string name);
    int mark;
    mark = err_cnt;
    skip_cycles(40);
    write_reg(1'b0, 24'(pat));
    wait_frames(2);
    finish_test(name, mark);
  endtask

  initial begin
    int mark;
    int k;
    sys_clk   = 1'b0;
    sys_rst_n = 1'b0;
    wr_en     = 1'b0;
    wr_addr   = '0;
    wr_data   = '0;
    disp[0]   = 0;
    disp[1]   = 0;
    disp[2]   = 0;
    repeat (3) @(posedge sys_clk);
    #1;
    sys_rst_n = 1'b1;

    mark = err_cnt;
    wait_frames(2);                         // frame 0 black, tokens checked
    finish_test("reset and tokens", mark);

    mark = err_cnt;
    skip_cycles(40);
    write_reg(1'b0, 24'(video_pkg::pat_solid));
    for (k = 0; k < 3; k++) begin
      write_reg(1'b1, 24'($random(seed)));
      wait_frames(1);
      skip_cycles(40);                      // running frame keeps the old colour
    end
    wait_frames(1);
    finish_test("solid colours", mark);

    run_pattern(video_pkg::pat_bars, "colour bars");
    run_pattern(video_pkg::pat_hramp, "horizontal ramp");
    run_pattern(video_pkg::pat_xor, "xor texture");

    $display("tests passed %0d failed %0d, errors %0d", pass_tests, fail_tests, err_cnt);
    if ((fail_tests == 0) && (err_cnt == 0)) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // whole sequence needs about 11 frames
  initial begin
    #(12 * FRAME_CYC * 10);
    $display("watchdog expired before the test sequence finished");
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- dvi_tx_top.sv
module dvi_tx_top #(
  parameter int H_ACTIVE = 640,
  parameter int H_FP     = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BP     = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FP     = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BP     = 33
) (
  input  logic                 sys_clk,
  input  logic                 sys_rst_n,
  input  logic                 wr_en,
  input  video_pkg::cfg_addr_t wr_addr,
  input  logic [23:0]          wr_data,
  output tmds_pkg::tmds_word_t tmds_ch0,  // blue, carries hsync and vsync
  output tmds_pkg::tmds_word_t tmds_ch1,  // green
  output tmds_pkg::tmds_word_t tmds_ch2   // red
);

  // timing stage
  logic                de_t;
  logic                hsync_t;
  logic                vsync_t;
  logic                frame_start;
  video_pkg::coord_t   pix_x;
  video_pkg::coord_t   pix_y;
  // frame settings
  video_pkg::pattern_t pattern_sel;
  video_pkg::rgb_t     solid_rgb;
  // pixel stage, one cycle later
  video_pkg::rgb_t     pix_rgb;
  logic                de_p;
  logic                hsync_p;
  logic                vsync_p;

  video_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FP     (H_FP),
    .H_SYNC   (H_SYNC),
    .H_BP     (H_BP),
    .V_ACTIVE (V_ACTIVE),
    .V_FP     (V_FP),
    .V_SYNC   (V_SYNC),
    .V_BP     (V_BP)
  ) video_timing_i (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .de_t        (de_t),
    .hsync_t     (hsync_t),
    .vsync_t     (vsync_t),
    .frame_start (frame_start),
    .pix_x       (pix_x),
    .pix_y       (pix_y)
  );

  dvi_cfg_regs dvi_cfg_regs_i (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .frame_start (frame_start),
    .pattern_sel (pattern_sel),
    .solid_rgb   (solid_rgb)
  );

  pattern_gen #(
    .H_ACTIVE (H_ACTIVE)
  ) pattern_gen_i (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .de_t        (de_t),
    .hsync_t     (hsync_t),
    .vsync_t     (vsync_t),
    .pix_x       (pix_x),
    .pix_y       (pix_y),
    .pattern_sel (pattern_sel),
    .solid_rgb   (solid_rgb),
    .pix_rgb     (pix_rgb),
    .de_p        (de_p),
    .hsync_p     (hsync_p),
    .vsync_p     (vsync_p)
  );

  ////////////////////////////////////////
  // one encoder per colour channel
  ////////////////////////////////////////

  tmds_encode enc_blue (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .de        (de_p),
    .c0        (hsync_p),
    .c1        (vsync_p),
    .data_in   (pix_rgb[7:0]),
    .data_out  (tmds_ch0)
  );

  tmds_encode enc_green (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .de        (de_p),
    .c0        (1'b0),                    // no control data on green
    .c1        (1'b0),
    .data_in   (pix_rgb[15:8]),
    .data_out  (tmds_ch1)
  );

  tmds_encode enc_red (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .de        (de_p),
    .c0        (1'b0),
    .c1        (1'b0),
    .data_in   (pix_rgb[23:16]),
    .data_out  (tmds_ch2)
  );

endmodule

//--- dvi_cfg_regs.sv
module dvi_cfg_regs (
  input  logic                 sys_clk,
  input  logic                 sys_rst_n,
  input  logic                 wr_en,       // one-cycle write strobe
  input  video_pkg::cfg_addr_t wr_addr,
  input  logic [23:0]          wr_data,
  input  logic                 frame_start,
  output video_pkg::pattern_t  pattern_sel,
  output video_pkg::rgb_t      solid_rgb
);

  ////////////////////////////////////////
  // staging copies written by software
  ////////////////////////////////////////

  video_pkg::pattern_t stg_pattern;
  video_pkg::rgb_t     stg_rgb;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      stg_pattern <= video_pkg::pat_solid;
      stg_rgb     <= '0;
    end else if (wr_en) begin
      if (wr_addr == 1'b0) begin
        stg_pattern <= video_pkg::pattern_t'(wr_data[1:0]);
      end else begin
        stg_rgb <= wr_data;
      end
    end
  end

  ////////////////////////////////////////
  // active copies, frame boundary only
  ////////////////////////////////////////

  video_pkg::pattern_t act_pattern;
  video_pkg::rgb_t     act_rgb;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      act_pattern <= video_pkg::pat_solid;
      act_rgb     <= '0;
    end else if (frame_start) begin
      act_pattern <= stg_pattern;         // held from the cycle after frame_start
      act_rgb     <= stg_rgb;
    end
  end

  // pixel 0,0 is sampled in the frame_start cycle itself
  // so the staging values are passed straight out for that one cycle
  assign pattern_sel = frame_start ? stg_pattern : act_pattern;
  assign solid_rgb   = frame_start ? stg_rgb : act_rgb;

endmodule

//--- pattern_gen.sv
module pattern_gen #(
  parameter int H_ACTIVE = 640
) (
  input  logic                sys_clk,
  input  logic                sys_rst_n,
  input  logic                de_t,
  input  logic                hsync_t,
  input  logic                vsync_t,
  input  video_pkg::coord_t   pix_x,
  input  video_pkg::coord_t   pix_y,
  input  video_pkg::pattern_t pattern_sel,
  input  video_pkg::rgb_t     solid_rgb,
  output video_pkg::rgb_t     pix_rgb,    // one cycle after de_t
  output logic                de_p,
  output logic                hsync_p,
  output logic                vsync_p
);

  localparam video_pkg::coord_t BAR_W = video_pkg::coord_t'(H_ACTIVE / 8);

  logic [2:0]      bar_idx;               // 0..7 across the active width
  logic [7:0]      xor_val;
  video_pkg::rgb_t rgb_next;

  assign bar_idx = 3'(pix_x / BAR_W);
  assign xor_val = pix_x[7:0] ^ pix_y[7:0];

  always_comb begin
    case (pattern_sel)
      video_pkg::pat_solid: rgb_next = solid_rgb;
      // bit 2 red, bit 1 green, bit 0 blue
      video_pkg::pat_bars:  rgb_next = {{8{bar_idx[2]}}, {8{bar_idx[1]}}, {8{bar_idx[0]}}};
      video_pkg::pat_hramp: rgb_next = {3{pix_x[7:0]}};
      default:              rgb_next = {3{xor_val}};     // pat_xor
    endcase
  end

  always_ff @(posedge sys_clk) begin
    pix_rgb <= rgb_next;
  end

  ////////////////////////////////////////
  // align de and syncs with the pixel
  ////////////////////////////////////////

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      de_p    <= 1'b0;
      hsync_p <= 1'b0;
      vsync_p <= 1'b0;
    end else begin
      de_p    <= de_t;
      hsync_p <= hsync_t;
      vsync_p <= vsync_t;
    end
  end

endmodule

//--- video_timing.sv
module video_timing #(
  parameter int H_ACTIVE = 640,
  parameter int H_FP     = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BP     = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FP     = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BP     = 33
) (
  input  logic              sys_clk,
  input  logic              sys_rst_n,
  output logic              de_t,         // active video
  output logic              hsync_t,      // active high
  output logic              vsync_t,      // active high
  output logic              frame_start,  // one cycle at x 0, y 0
  output video_pkg::coord_t pix_x,
  output video_pkg::coord_t pix_y
);

  // region edges, each line is active, front porch, sync, back porch
  localparam video_pkg::coord_t H_LAST =
    video_pkg::coord_t'(H_ACTIVE + H_FP + H_SYNC + H_BP - 1);
  localparam video_pkg::coord_t V_LAST =
    video_pkg::coord_t'(V_ACTIVE + V_FP + V_SYNC + V_BP - 1);
  localparam video_pkg::coord_t H_ACT  = video_pkg::coord_t'(H_ACTIVE);
  localparam video_pkg::coord_t V_ACT  = video_pkg::coord_t'(V_ACTIVE);
  localparam video_pkg::coord_t HS_BEG = video_pkg::coord_t'(H_ACTIVE + H_FP);
  localparam video_pkg::coord_t HS_END = video_pkg::coord_t'(H_ACTIVE + H_FP + H_SYNC);
  localparam video_pkg::coord_t VS_BEG = video_pkg::coord_t'(V_ACTIVE + V_FP);
  localparam video_pkg::coord_t VS_END = video_pkg::coord_t'(V_ACTIVE + V_FP + V_SYNC);

  ////////////////////////////////////////
  // raster counters
  ////////////////////////////////////////

  video_pkg::coord_t h_cnt;
  video_pkg::coord_t v_cnt;
  logic              h_wrap;              // last pixel of the line

  assign h_wrap = (h_cnt == H_LAST);

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else begin
      if (h_wrap) begin
        h_cnt <= '0;
        // next line, or back to the top
        v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // region decode
  ////////////////////////////////////////

  logic h_act;
  logic v_act;
  logic h_sync_lvl;
  logic v_sync_lvl;

  assign h_act      = (h_cnt < H_ACT);
  assign v_act      = (v_cnt < V_ACT);
  assign h_sync_lvl = (h_cnt >= HS_BEG) && (h_cnt < HS_END);
  assign v_sync_lvl = (v_cnt >= VS_BEG) && (v_cnt < VS_END);  // whole lines

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      de_t        <= 1'b0;
      hsync_t     <= 1'b0;
      vsync_t     <= 1'b0;
      frame_start <= 1'b0;
    end else begin
      de_t        <= h_act && v_act;
      hsync_t     <= h_sync_lvl;
      vsync_t     <= v_sync_lvl;
      frame_start <= (h_cnt == '0) && (v_cnt == '0);
    end
  end

  // coordinates registered in step with de_t
  always_ff @(posedge sys_clk) begin
    pix_x <= h_cnt;
    pix_y <= v_cnt;
  end

endmodule

//--- tmds_encode.sv
module tmds_encode (
  input  logic                 sys_clk,
  input  logic                 sys_rst_n,
  input  logic                 de,        // high during active video
  input  logic                 c0,        // control bit 0, sent in blanking
  input  logic                 c1,        // control bit 1
  input  tmds_pkg::tmds_byte_t data_in,   // colour component
  output tmds_pkg::tmds_word_t data_out   // 10-bit symbol, 3 cycles after data_in
);

  ////////////////////////////////////////
  // stage 1 count ones of the input byte
  ////////////////////////////////////////

  logic [3:0]           n1d;              // ones in data_in
  tmds_pkg::tmds_byte_t data_in_q;

  always_ff @(posedge sys_clk) begin
    n1d       <= 4'($countones(data_in));
    data_in_q <= data_in;                 // keep byte next to its count
  end

  ////////////////////////////////////////
  // stage 2 transition minimising 8 -> 9
  ////////////////////////////////////////

  logic       use_xnor;
  logic [8:0] q_m;                        // transition-minimised word
  logic [8:0] q_m_q;
  logic [3:0] n1q_m;                      // ones in q_m_q[7:0]
  logic [3:0] n0q_m;                      // zeros in q_m_q[7:0]

  // xnor chain when the byte is ones-heavy
  assign use_xnor = (n1d > 4'd4) || ((n1d == 4'd4) && !data_in_q[0]);

  always_comb begin
    q_m[0] = data_in_q[0];
    for (int i = 1; i < 8; i++) begin
      q_m[i] = use_xnor ? ~(q_m[i-1] ^ data_in_q[i]) : (q_m[i-1] ^ data_in_q[i]);
    end
    q_m[8] = ~use_xnor;                   // 1 marks the xor form
  end

  always_ff @(posedge sys_clk) begin
    q_m_q <= q_m;
    n1q_m <= 4'($countones(q_m[7:0]));
    n0q_m <= 4'd8 - 4'($countones(q_m[7:0]));
  end

  // de and control bits follow the data through both stages
  logic de_q;
  logic de_qq;
  logic c0_q;
  logic c0_qq;
  logic c1_q;
  logic c1_qq;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      de_q  <= 1'b0;
      de_qq <= 1'b0;
      c0_q  <= 1'b0;
      c0_qq <= 1'b0;
      c1_q  <= 1'b0;
      c1_qq <= 1'b0;
    end else begin
      de_q  <= de;
      de_qq <= de_q;
      c0_q  <= c0;
      c0_qq <= c0_q;
      c1_q  <= c1;
      c1_qq <= c1_q;
    end
  end

  ////////////////////////////////////////
  // stage 3 dc balance 9 -> 10
  ////////////////////////////////////////

  tmds_pkg::disparity_t cnt;              // running disparity
  tmds_pkg::disparity_t cnt_next;
  tmds_pkg::disparity_t balance;          // ones minus zeros of q_m_q[7:0]
  tmds_pkg::disparity_t q8_x2;            // 2 when bit 8 set
  tmds_pkg::disparity_t nq8_x2;           // 2 when bit 8 clear
  tmds_pkg::tmds_word_t word_next;

  assign balance = tmds_pkg::disparity_t'({1'b0, n1q_m}) - tmds_pkg::disparity_t'({1'b0, n0q_m});
  assign q8_x2   = q_m_q[8] ? 5'sd2 : 5'sd0;
  assign nq8_x2  = q_m_q[8] ? 5'sd0 : 5'sd2;

  always_comb begin
    if ((cnt == 5'sd0) || (n1q_m == n0q_m)) begin
      // no bias to correct, bit 8 decides the polarity
      word_next = {~q_m_q[8], q_m_q[8], q_m_q[8] ? q_m_q[7:0] : ~q_m_q[7:0]};
      cnt_next  = q_m_q[8] ? (cnt + balance) : (cnt - balance);
    end else if (((cnt > 5'sd0) && (n1q_m > n0q_m)) ||
                 ((cnt < 5'sd0) && (n0q_m > n1q_m))) begin
      word_next = {1'b1, q_m_q[8], ~q_m_q[7:0]};  // invert to pull back
      cnt_next  = cnt + q8_x2 - balance;
    end else begin
      word_next = {1'b0, q_m_q[8], q_m_q[7:0]};   // send as is
      cnt_next  = cnt - nq8_x2 + balance;
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      data_out <= '0;
      cnt      <= '0;
    end else if (de_qq) begin
      data_out <= word_next;
      cnt      <= cnt_next;
    end else begin
      case ({c1_qq, c0_qq})
        2'b00:   data_out <= tmds_pkg::ctrl_token_0;
        2'b01:   data_out <= tmds_pkg::ctrl_token_1;
        2'b10:   data_out <= tmds_pkg::ctrl_token_2;
        default: data_out <= tmds_pkg::ctrl_token_3;
      endcase
      cnt <= '0;                          // balance restarts after blanking
    end
  end

endmodule

//--- video_pkg.sv
package video_pkg;

  ////////////////////////////////////////
  // raster types
  ////////////////////////////////////////

  typedef logic [11:0] coord_t;            // pixel column or line number
  typedef logic [23:0] rgb_t;              // {red, green, blue}, 8 bits each

  ////////////////////////////////////////
  // pattern select
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    pat_solid = 2'd0,                      // programmed colour everywhere
    pat_bars  = 2'd1,                      // eight vertical colour bars
    pat_hramp = 2'd2,                      // grey ramp on x
    pat_xor   = 2'd3                       // x xor y texture
  } pattern_t;

  // register map
  // addr 0 pattern in data[1:0]
  // addr 1 solid colour in data[23:0]
  typedef logic [0:0] cfg_addr_t;

endpackage

//--- tmds_pkg.sv
package tmds_pkg;

  ////////////////////////////////////////
  // channel word and input byte
  ////////////////////////////////////////

  typedef logic [9:0] tmds_word_t;         // one 10-bit symbol on a channel
  typedef logic [7:0] tmds_byte_t;         // one colour component into the encoder

  // running balance of ones minus zeros, counted in pairs of bits
  // msb is the sign
  typedef logic signed [4:0] disparity_t;

  ////////////////////////////////////////
  // blanking tokens
  ////////////////////////////////////////

  // picked by {c1, c0} while de is low
  parameter tmds_word_t ctrl_token_0 = 10'b1101010100;  // c1 c0 = 00
  parameter tmds_word_t ctrl_token_1 = 10'b0010101011;  // c1 c0 = 01
  parameter tmds_word_t ctrl_token_2 = 10'b0101010100;  // c1 c0 = 10
  parameter tmds_word_t ctrl_token_3 = 10'b1010101011;  // c1 c0 = 11

  // all four tokens have many transitions so the receiver
  // can find the symbol boundary during blanking

endpackage
